// ==== bench/port_checker.sv ====
`default_nettype none

module port_checker #(
  parameter int fifo_depth = 8
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [noc_pkg::num_ports-1:0]                      in_valid,
  input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] in_flit,
  input  logic [noc_pkg::num_ports-1:0]                      in_full,
  input  logic                                               dcts,
  input  logic                                               rts,
  input  logic [noc_pkg::flit_w-1:0]                         out_flit,
  input  logic                                               order_en,
  output int                                                 errors,
  output int                                                 moved,
  output int                                                 pending
);
  import noc_pkg::*;

  // one ring per input port, mirroring the flits that sit in its FIFO
  logic [flit_w-1:0] exp_mem [num_ports][64];
  int exp_rd [num_ports];
  int exp_cnt [num_ports];
  logic held;
  logic [flit_w-1:0] held_flit;
  int pkt_port;
  int pkt_left;
  int order_idx;
  logic order_prev;

  task automatic flag_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    errors++;
  endtask

  always @(posedge clk) begin
    int src;
    logic [flit_w-1:0] want;
    if (rst) begin
      for (int i = 0; i < num_ports; i++) begin
        exp_rd[i] = 0;
        exp_cnt[i] = 0;
      end
      errors = 0;
      moved = 0;
      pending = 0;
      held = 1'b0;
      pkt_port = 0;
      pkt_left = 0;
      order_idx = 0;
      order_prev = 1'b0;
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        if (in_full[i] !== (exp_cnt[i] == fifo_depth))
          flag_mismatch($sformatf("in_full[%0d]", i), in_full[i], exp_cnt[i] == fifo_depth);
      end
      // an offered flit must wait unchanged until the receiver takes it
      if (held && rts !== 1'b1) flag_mismatch("rts", rts, 1);
      if (held && out_flit !== held_flit) flag_mismatch("out_flit", out_flit, held_flit);
      if (rts === 1'b1 && pending == 0) begin
        $display("error at %0t: rts is high while no written flit is waiting", $time);
        errors++;
      end
      if (order_en && !order_prev) order_idx = 0;
      if (rts === 1'b1 && dcts === 1'b1) begin
        src = -1;
        want = '0;
        // inside a packet only the owner's head is a legal flit
        for (int i = num_ports - 1; i >= 0; i--) begin
          if (exp_cnt[i] > 0 && (pkt_left == 0 || i == pkt_port)) begin
            want = exp_mem[i][exp_rd[i]];
            if (want === out_flit) src = i;
          end
        end
        if (src < 0) begin
          flag_mismatch("out_flit", out_flit, want);
        end else begin
          exp_rd[src] = (exp_rd[src] + 1) % 64;
          exp_cnt[src]--;
          moved++;
          if (pkt_left > 0) begin
            pkt_left--;
          end else begin
            if (out_flit[kind_hi:kind_lo] !== header)
              flag_mismatch("out_flit kind", out_flit[kind_hi:kind_lo], header);
            pkt_port = src;
            pkt_left = out_flit[len_hi:len_lo];
            // from idle local goes first, then the rotation n, e, w, s
            if (order_en && src != (order_idx + port_l) % num_ports)
              flag_mismatch("header port", src, (order_idx + port_l) % num_ports);
            order_idx++;
          end
        end
      end
      for (int i = 0; i < num_ports; i++) begin
        if (in_valid[i]) begin
          exp_mem[i][(exp_rd[i] + exp_cnt[i]) % 64] = in_flit[i];
          exp_cnt[i]++;
        end
      end
      if (order_prev && !order_en && order_idx != num_ports) begin
        $display("error at %0t: rotation test saw %0d packets instead of %0d", $time,
                 order_idx, num_ports);
        errors++;
      end
      order_prev = order_en;
      held = (rts === 1'b1) && (dcts !== 1'b1);
      held_flit = out_flit;
      pending = 0;
      for (int i = 0; i < num_ports; i++) pending += exp_cnt[i];
    end
  end

endmodule

`default_nettype wire

// ==== bench/tb_router_out_port.sv ====
`default_nettype none

module tb_router_out_port;
  import noc_pkg::*;

  localparam int fifo_depth = 8;
  localparam int src_slots = 32;

  logic clk;
  logic rst;
  logic [num_ports-1:0] in_valid;
  logic [num_ports-1:0][flit_w-1:0] in_flit;
  logic dcts;
  logic [num_ports-1:0] in_full;
  logic [flit_w-1:0] out_flit;
  logic rts;
  logic order_en;
  int chk_errors;
  int moved;
  int pending;

  // flits generated but not yet written, per source port
  logic [flit_w-1:0] src_mem [num_ports][src_slots];
  int src_rd [num_ports];
  int src_cnt [num_ports];
  int seq [num_ports];
  int tb_errors;
  int test_base;

  router_out_port #(.fifo_depth(fifo_depth)) dut0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_flit(in_flit), .dcts(dcts),
    .in_full(in_full), .out_flit(out_flit), .rts(rts)
  );

  port_checker #(.fifo_depth(fifo_depth)) chk0 (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_flit(in_flit), .in_full(in_full),
    .dcts(dcts), .rts(rts), .out_flit(out_flit), .order_en(order_en),
    .errors(chk_errors), .moved(moved), .pending(pending)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // flit = kind, source port, sequence number, length or filler
  task automatic queue_packet(input int p, input int max_len);
    int len;
    flit_kind_t kind;
    len = $urandom % (max_len + 1);
    for (int k = 0; k <= len; k++) begin
      kind = (k == 0) ? header : ((k == len) ? tail : body);
      src_mem[p][(src_rd[p] + src_cnt[p]) % src_slots] =
        {kind, 3'(p), 23'(seq[p]), (k == 0) ? 4'(len) : 4'($urandom)};
      seq[p]++;
      src_cnt[p]++;
    end
  endtask

  function automatic int src_total();
    int n;
    n = 0;
    for (int p = 0; p < num_ports; p++) n += src_cnt[p];
    return n;
  endfunction

  task automatic drive_inputs(input int write_pct, input int new_pct, input int dcts_pct);
    @(negedge clk);
    for (int p = 0; p < num_ports; p++) begin
      if (src_cnt[p] == 0 && ($urandom % 100) < new_pct) queue_packet(p, 15);
      in_valid[p] = 1'b0;
      if (src_cnt[p] > 0 && !in_full[p] && ($urandom % 100) < write_pct) begin
        in_valid[p] = 1'b1;
        in_flit[p] = src_mem[p][src_rd[p]];
        src_rd[p] = (src_rd[p] + 1) % src_slots;
        src_cnt[p]--;
      end
    end
    dcts = ($urandom % 100) < dcts_pct;
  endtask

  // writes out what is left and optionally waits for the port to go quiet
  task automatic feed(input int dcts_pct, input int limit, input bit to_empty, input string what);
    int n;
    n = 0;
    while ((src_total() != 0 || (to_empty && (pending != 0 || rts))) && n < limit) begin
      drive_inputs(100, 0, dcts_pct);
      n++;
    end
    if (src_total() != 0 || (to_empty && (pending != 0 || rts))) begin
      $display("timeout: %s did not finish within %0d cycles", what, limit);
      tb_errors++;
    end
  endtask

  task automatic end_test(input string name);
    int n;
    n = chk_errors + tb_errors - test_base;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, n);
    end
    test_base = chk_errors + tb_errors;
  endtask

  initial begin
    int n;
    int dens;
    int wpct;
    n = $urandom(32'h9b482a45);
    rst = 1'b1;
    in_valid = '0;
    in_flit = '0;
    dcts = 1'b0;
    order_en = 1'b0;
    tb_errors = 0;
    test_base = 0;
    for (int p = 0; p < num_ports; p++) begin
      src_rd[p] = 0;
      src_cnt[p] = 0;
      seq[p] = 0;
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;

    repeat (12) drive_inputs(0, 0, 50);
    end_test("reset and idle");

    // every FIFO gets its header in the same cycle, so the idle rule decides
    order_en = 1'b1;
    for (int p = 0; p < num_ports; p++) queue_packet(p, fifo_depth - 2);
    feed(0, 50, 1'b0, "rotation load");
    feed(100, 500, 1'b1, "rotation drain");
    order_en = 1'b0;
    drive_inputs(0, 0, 100);
    end_test("priority rotation");

    n = 0;
    while (in_full != '1 && n < 200) begin
      drive_inputs(100, 100, 0);
      n++;
    end
    if (in_full != '1) begin
      $display("timeout: in_full did not rise on every port while dcts was low");
      tb_errors++;
    end
    feed(50, 2000, 1'b1, "back-pressure release");
    end_test("back-pressure");

    for (int blk = 0; blk < 40; blk++) begin
      dens = 10 + $urandom % 91;
      wpct = 20 + $urandom % 81;
      repeat (100) drive_inputs(wpct, 30, dens);
    end
    end_test("random traffic");

    feed(100, 3000, 1'b1, "final drain");
    end_test("drain");

    if (moved == 0) begin
      $display("error: no flit was ever transferred");
      tb_errors++;
    end
    $display("summary: 5 tests, %0d flits checked, %0d checker errors, %0d other errors",
             moved, chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
logic/noc_pkg.sv
logic/input_fifo.sv
logic/port_arbiter.sv
logic/packet_counter.sv
logic/xbar_mux.sv
logic/router_out_port.sv
bench/port_checker.sv
bench/tb_router_out_port.sv

// ==== logic/input_fifo.sv ====
`default_nettype none

module input_fifo #(
  parameter int fifo_depth = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wr_en,
  input  logic [noc_pkg::flit_w-1:0] wr_data,
  output logic                       full,
  input  logic                       rd_en,
  output logic [noc_pkg::flit_w-1:0] rd_data,
  output logic                       empty
);
  import noc_pkg::*;

  localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_w = $clog2(fifo_depth + 1);

  logic [flit_w-1:0] mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic do_wr;
  logic do_rd;

  // pointers wrap at the depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count == cnt_w'(fifo_depth));
  assign empty = (count == '0);
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // the head flit is visible straight from the array
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= bump(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= bump(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // the source watches in_full, and the arbiter only grants a requesting port
  assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
    else $error("input_fifo: write while full");
  assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
    else $error("input_fifo: read while empty");

endmodule

`default_nettype wire

// ==== logic/noc_pkg.sv ====
`default_nettype none

package noc_pkg;

  // router geometry
  localparam int num_ports = 5;

  // port indices into request, grant and select vectors
  localparam int port_n = 0;
  localparam int port_e = 1;
  localparam int port_w = 2;
  localparam int port_s = 3;
  localparam int port_l = 4;

  // flit layout: kind in the top two bits, length in the low bits of a header
  localparam int flit_w = 32;
  localparam int len_w = 4;
  localparam int kind_hi = flit_w - 1;
  localparam int kind_lo = flit_w - 2;
  localparam int len_hi = len_w - 1;
  localparam int len_lo = 0;

  // a header with length zero is a packet of one flit
  typedef enum logic [1:0] {
    header = 2'b01,
    body = 2'b10,
    tail = 2'b11
  } flit_kind_t;

  typedef enum logic [5:0] {
    idle = 6'b000001,
    own_l = 6'b000010,
    own_n = 6'b000100,
    own_e = 6'b001000,
    own_w = 6'b010000,
    own_s = 6'b100000
  } state_t;

endpackage

`default_nettype wire

// ==== logic/packet_counter.sv ====
`default_nettype none

module packet_counter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fire,
  input  logic [noc_pkg::flit_w-1:0] flit,
  output logic                       packet_open
);
  import noc_pkg::*;

  flit_kind_t kind;
  logic [len_w-1:0] len;
  logic [len_w-1:0] remaining;

  assign kind = flit_kind_t'(flit[kind_hi:kind_lo]);
  assign len = flit[len_hi:len_lo];

  // remaining counts the flits after the header that have not yet left
  always_ff @(posedge clk) begin
    if (rst) begin
      remaining <= '0;
      packet_open <= 1'b0;
    end else if (fire) begin
      if (kind == header) begin
        remaining <= len;
        packet_open <= (len != '0);
      end else if (packet_open) begin
        remaining <= remaining - 1'b1;
        // this is the tail leaving
        if (remaining == len_w'(1)) begin
          packet_open <= 1'b0;
        end
      end
    end
  end

  // the arbiter must not switch to a new packet before the old tail has gone
  assert property (@(posedge clk) disable iff (rst)
    fire && packet_open |-> kind != header)
    else $error("packet_counter: header fired inside an open packet");

endmodule

`default_nettype wire

// ==== logic/port_arbiter.sv ====
`default_nettype none

module port_arbiter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [noc_pkg::num_ports-1:0] req,
  input  logic                          dcts,
  input  logic                          packet_open,
  output logic [noc_pkg::num_ports-1:0] grant,
  output logic [noc_pkg::num_ports-1:0] xbar_sel,
  output logic                          rts
);
  import noc_pkg::*;

  state_t state;
  state_t state_in;
  state_t next_state;
  logic rts_ff;
  logic rts_in;
  logic owner_req;
  int unsigned start_idx;

  function automatic state_t owner_state(input int unsigned idx);
    state_t s;
    case (idx)
      port_n: s = own_n;
      port_e: s = own_e;
      port_w: s = own_w;
      port_s: s = own_s;
      default: s = own_l;
    endcase
    return s;
  endfunction

  // decode the owner and where its rotation starts, idle starts at local
  always_comb begin
    xbar_sel = '0;
    start_idx = port_l;
    case (state)
      own_n: begin
        xbar_sel[port_n] = 1'b1;
        start_idx = port_n;
      end
      own_e: begin
        xbar_sel[port_e] = 1'b1;
        start_idx = port_e;
      end
      own_w: begin
        xbar_sel[port_w] = 1'b1;
        start_idx = port_w;
      end
      own_s: begin
        xbar_sel[port_s] = 1'b1;
        start_idx = port_s;
      end
      own_l: begin
        xbar_sel[port_l] = 1'b1;
        start_idx = port_l;
      end
      default: begin
        xbar_sel = '0;
        start_idx = port_l;
      end
    endcase
  end

  assign owner_req = |(req & xbar_sel);

  // the owner keeps priority and the others follow n, e, w, s, l in rotation
  always_comb begin
    int unsigned idx;
    idx = 0;
    next_state = idle;
    if (packet_open) begin
      next_state = state;
    end else begin
      // walk the rotation backwards so the earliest requester is written last
      for (int k = num_ports; k > 0; k--) begin
        idx = (start_idx + k - 1) % num_ports;
        if (req[idx]) begin
          next_state = owner_state(idx);
        end
      end
    end
  end

  // the state freezes while a flit is offered and the receiver is not ready
  always_comb begin
    if (rts_ff && !dcts) begin
      state_in = state;
    end else begin
      state_in = next_state;
    end
  end

  // rts drops for a cycle after each transfer and waits for a flit in the owner's FIFO
  always_comb begin
    if (state == idle) begin
      rts_in = 1'b0;
    end else if (rts_ff && dcts) begin
      rts_in = 1'b0;
    end else begin
      rts_in = owner_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      rts_ff <= 1'b0;
    end else begin
      state <= state_in;
      rts_ff <= rts_in;
    end
  end

  assign rts = rts_ff;
  assign grant = xbar_sel & {num_ports{rts_ff && dcts}};

  // an offered flit must sit at the head of the owner's FIFO
  assert property (@(posedge clk) disable iff (rst) rts_ff |-> |(req & xbar_sel))
    else $error("port_arbiter: rts high without a flit in the owner's FIFO");
  assert property (@(posedge clk) disable iff (rst)
    rts_ff && !dcts |=> rts_ff && $stable(xbar_sel))
    else $error("port_arbiter: offered flit withdrawn before the receiver took it");

endmodule

`default_nettype wire

// ==== logic/router_out_port.sv ====
`default_nettype none

module router_out_port #(
  parameter int fifo_depth = 8
) (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic [noc_pkg::num_ports-1:0]                      in_valid,
  input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] in_flit,
  input  logic                                               dcts,
  output logic [noc_pkg::num_ports-1:0]                      in_full,
  output logic [noc_pkg::flit_w-1:0]                         out_flit,
  output logic                                               rts
);
  import noc_pkg::*;

  logic [num_ports-1:0] empty;
  logic [num_ports-1:0] req;
  logic [num_ports-1:0] grant;
  logic [num_ports-1:0] xbar_sel;
  logic [num_ports-1:0][flit_w-1:0] heads;
  logic fire;
  logic packet_open;

  assign req = ~empty;

  // a flit moves whenever one grant is up
  assign fire = |grant;

  for (genvar i = 0; i < num_ports; i++) begin : g_fifo
    input_fifo #(
      .fifo_depth(fifo_depth)
    ) u_fifo (
      .clk(clk),
      .rst(rst),
      .wr_en(in_valid[i]),
      .wr_data(in_flit[i]),
      .full(in_full[i]),
      .rd_en(grant[i]),
      .rd_data(heads[i]),
      .empty(empty[i])
    );
  end

  port_arbiter u_arbiter (
    .clk(clk),
    .rst(rst),
    .req(req),
    .dcts(dcts),
    .packet_open(packet_open),
    .grant(grant),
    .xbar_sel(xbar_sel),
    .rts(rts)
  );

  // the counter sees the same flit that goes downstream
  packet_counter u_counter (
    .clk(clk),
    .rst(rst),
    .fire(fire),
    .flit(out_flit),
    .packet_open(packet_open)
  );

  xbar_mux u_mux (
    .sel(xbar_sel),
    .heads(heads),
    .out_flit(out_flit)
  );

endmodule

`default_nettype wire

// ==== logic/xbar_mux.sv ====
`default_nettype none

module xbar_mux (
  input  logic [noc_pkg::num_ports-1:0]                      sel,
  input  logic [noc_pkg::num_ports-1:0][noc_pkg::flit_w-1:0] heads,
  output logic [noc_pkg::flit_w-1:0]                         out_flit
);
  import noc_pkg::*;

  // and-or selection, nothing selected gives an all-zero flit
  always_comb begin
    out_flit = '0;
    for (int i = 0; i < num_ports; i++) begin
      out_flit |= heads[i] & {flit_w{sel[i]}};
    end
  end

  // two select bits would merge two flits into garbage
  always_comb begin
    assert final ($onehot0(sel))
      else $error("xbar_mux: select is not one-hot");
  end

endmodule

`default_nettype wire
